/* hw/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [15:0] data_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] inst_t;
    typedef logic [2:0]  reg_addr_t;

    // instruction field positions
    localparam int OP_HI    = 15;
    localparam int OP_LO    = 11;
    localparam int RX_HI    = 10;
    localparam int RX_LO    = 8;
    localparam int RY_HI    = 7;
    localparam int RY_LO    = 5;
    localparam int RZ_HI    = 4;
    localparam int RZ_LO    = 2;
    localparam int FUNCT_HI = 1;
    localparam int FUNCT_LO = 0;
    localparam int IMM5_HI  = 4;
    localparam int IMM8_HI  = 7;
    localparam int IMM11_HI = 10;
    localparam int IMM_LO   = 0;

    // RRR function codes
    localparam logic [1:0] FUNCT_ADDU = 2'b01;
    localparam logic [1:0] FUNCT_SUBU = 2'b11;

    localparam int REG_COUNT = 8;

    typedef enum logic [4:0] {
        OP_NOP   = 5'b00001,
        OP_B     = 5'b00010,
        OP_BEQZ  = 5'b00100,
        OP_ADDIU = 5'b01001,
        OP_LI    = 5'b01101,
        OP_LW    = 5'b10011,
        OP_SW    = 5'b11011,
        OP_RRR   = 5'b11100
    } opcode_t;

    localparam inst_t NOP_INST = {OP_NOP, 11'b0};

    // zero encodings of these enums form the bubble
    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_PASS_B} alu_op_t;
    typedef enum logic [1:0] {BR_NONE, BR_ALWAYS, BR_ZERO} branch_t;
    typedef enum logic       {WB_ALU, WB_MEM} wb_sel_t;
    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      b_is_imm;
        logic      reg_write;
        wb_sel_t   wb_sel;
        logic      mem_read;
        logic      mem_write;
        branch_t   branch;
        reg_addr_t dest;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        addr_t     pc_next;
        data_t     a_data;
        data_t     b_data;
        data_t     imm;
        reg_addr_t rx;
        reg_addr_t ry;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        wb_sel_t   wb_sel;
        logic      mem_read;
        logic      mem_write;
        reg_addr_t dest;
        data_t     alu_result;
        data_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        data_t     wb_data;
    } mem_wb_t;

endpackage

/* hw/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit #(
    parameter cpu_pkg::addr_t RESET_PC = '0
) (
    input  logic           clk_50MHz,
    input  logic           rst,
    input  logic           load_stall,
    input  logic           branch_taken,
    input  cpu_pkg::addr_t branch_target,
    input  cpu_pkg::inst_t imem_data,
    output cpu_pkg::addr_t imem_addr,
    output cpu_pkg::inst_t if_inst,
    output cpu_pkg::addr_t if_pc_next
);

    cpu_pkg::addr_t pc;
    cpu_pkg::addr_t pc_plus_one;
    cpu_pkg::addr_t pc_sel;

    assign imem_addr   = pc;
    assign pc_plus_one = pc + 16'd1;

    // a taken branch wins over a load stall
    always_comb begin
        if (branch_taken) begin
            pc_sel = branch_target;
        end else if (load_stall) begin
            pc_sel = pc;
        end else begin
            pc_sel = pc_plus_one;
        end
    end

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_sel;
        end
    end

    // IF/ID register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            if_inst    <= cpu_pkg::NOP_INST;
            if_pc_next <= RESET_PC;
        end else if (branch_taken) begin
            if_inst    <= cpu_pkg::NOP_INST;
            if_pc_next <= pc_plus_one;
        end else if (!load_stall) begin
            if_inst    <= imem_data;
            if_pc_next <= pc_plus_one;
        end
    end

endmodule

/* hw/decoder.sv */
`timescale 1ns/100ps

module decoder (
    input  cpu_pkg::inst_t inst,
    output cpu_pkg::ctrl_t ctrl,
    output cpu_pkg::data_t imm
);

    cpu_pkg::opcode_t   opcode;
    logic [1:0]         funct;
    cpu_pkg::reg_addr_t rx;
    cpu_pkg::reg_addr_t rz;
    cpu_pkg::data_t     imm_z8;
    cpu_pkg::data_t     imm_s8;
    cpu_pkg::data_t     imm_s5;
    cpu_pkg::data_t     imm_s11;

    assign opcode = cpu_pkg::opcode_t'(inst[cpu_pkg::OP_HI:cpu_pkg::OP_LO]);
    assign funct  = inst[cpu_pkg::FUNCT_HI:cpu_pkg::FUNCT_LO];
    assign rx     = inst[cpu_pkg::RX_HI:cpu_pkg::RX_LO];
    assign rz     = inst[cpu_pkg::RZ_HI:cpu_pkg::RZ_LO];

    // immediate extension
    assign imm_z8  = 16'(inst[cpu_pkg::IMM8_HI:cpu_pkg::IMM_LO]);
    assign imm_s8  = 16'($signed(inst[cpu_pkg::IMM8_HI:cpu_pkg::IMM_LO]));
    assign imm_s5  = 16'($signed(inst[cpu_pkg::IMM5_HI:cpu_pkg::IMM_LO]));
    assign imm_s11 = 16'($signed(inst[cpu_pkg::IMM11_HI:cpu_pkg::IMM_LO]));

    always_comb begin
        // all-zero control is a bubble
        ctrl = '0;
        imm  = '0;
        case (opcode)
            cpu_pkg::OP_LI: begin
                ctrl.alu_op    = cpu_pkg::ALU_PASS_B;
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = rx;
                imm            = imm_z8;
            end
            cpu_pkg::OP_ADDIU: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = rx;
                imm            = imm_s8;
            end
            cpu_pkg::OP_RRR: begin
                if (funct == cpu_pkg::FUNCT_ADDU || funct == cpu_pkg::FUNCT_SUBU) begin
                    ctrl.alu_op    = (funct == cpu_pkg::FUNCT_SUBU) ?
                                     cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    ctrl.reg_write = 1'b1;
                    ctrl.dest      = rz;
                end
            end
            cpu_pkg::OP_LW: begin
                // rx <- mem[rx + imm5]
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = cpu_pkg::WB_MEM;
                ctrl.mem_read  = 1'b1;
                ctrl.dest      = rx;
                imm            = imm_s5;
            end
            cpu_pkg::OP_SW: begin
                // mem[rx + imm5] <- ry
                ctrl.b_is_imm  = 1'b1;
                ctrl.mem_write = 1'b1;
                imm            = imm_s5;
            end
            cpu_pkg::OP_B: begin
                ctrl.branch = cpu_pkg::BR_ALWAYS;
                imm         = imm_s11;
            end
            cpu_pkg::OP_BEQZ: begin
                ctrl.branch = cpu_pkg::BR_ZERO;
                imm         = imm_s8;
            end
            // nop and unknown opcodes stay a bubble
            default: ;
        endcase
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rd_addr_a,
    input  cpu_pkg::reg_addr_t rd_addr_b,
    input  cpu_pkg::mem_wb_t   wb,
    output cpu_pkg::data_t     rd_data_a,
    output cpu_pkg::data_t     rd_data_b
);

    cpu_pkg::data_t regs [cpu_pkg::REG_COUNT];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write) begin
            regs[wb.dest] <= wb.wb_data;
        end
    end

    // write-through so decode sees a same-cycle writeback
    assign rd_data_a = (wb.reg_write && wb.dest == rd_addr_a) ? wb.wb_data : regs[rd_addr_a];
    assign rd_data_b = (wb.reg_write && wb.dest == rd_addr_b) ? wb.wb_data : regs[rd_addr_b];

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
    input  cpu_pkg::reg_addr_t id_rx,
    input  cpu_pkg::reg_addr_t id_ry,
    input  logic               id_b_is_imm,
    input  cpu_pkg::id_ex_t    ex,
    input  cpu_pkg::ex_mem_t   mem,
    input  cpu_pkg::mem_wb_t   wb,
    output logic               load_stall,
    output cpu_pkg::fwd_sel_t  fwd_a_sel,
    output cpu_pkg::fwd_sel_t  fwd_b_sel
);

    logic hit_a;
    logic hit_b;

    // youngest pending writer first; a load in EX/MEM has no data yet
    function automatic cpu_pkg::fwd_sel_t pick_source(
        input cpu_pkg::reg_addr_t src,
        input cpu_pkg::ex_mem_t   m,
        input cpu_pkg::mem_wb_t   w
    );
        cpu_pkg::fwd_sel_t sel;
        if (m.reg_write && !m.mem_read && m.dest == src) begin
            sel = cpu_pkg::FWD_MEM;
        end else if (w.reg_write && w.dest == src) begin
            sel = cpu_pkg::FWD_WB;
        end else begin
            sel = cpu_pkg::FWD_REG;
        end
        return sel;
    endfunction

    // ************************************************************************
    // load-use detection
    // ************************************************************************

    // rx is taken as read whenever it might be, a spare bubble is harmless
    assign hit_a = (ex.ctrl.dest == id_rx);
    assign hit_b = !id_b_is_imm && (ex.ctrl.dest == id_ry);

    assign load_stall = ex.ctrl.mem_read && (hit_a || hit_b);

    // ************************************************************************
    // forwarding into execute
    // ************************************************************************

    always_comb begin
        fwd_a_sel = pick_source(ex.rx, mem, wb);
        fwd_b_sel = pick_source(ex.ry, mem, wb);
    end

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/100ps

module execute_unit (
    input  cpu_pkg::id_ex_t   ex,
    input  cpu_pkg::fwd_sel_t fwd_a_sel,
    input  cpu_pkg::fwd_sel_t fwd_b_sel,
    input  cpu_pkg::data_t    mem_fwd,
    input  cpu_pkg::data_t    wb_fwd,
    output cpu_pkg::ex_mem_t  result,
    output logic              branch_taken,
    output cpu_pkg::addr_t    branch_target
);

    cpu_pkg::data_t op_a;
    cpu_pkg::data_t ry_val;
    cpu_pkg::data_t op_b;
    cpu_pkg::data_t alu_y;

    function automatic cpu_pkg::data_t resolve(
        input cpu_pkg::fwd_sel_t sel,
        input cpu_pkg::data_t    reg_val,
        input cpu_pkg::data_t    mem_val,
        input cpu_pkg::data_t    wb_val
    );
        cpu_pkg::data_t val;
        case (sel)
            cpu_pkg::FWD_MEM: val = mem_val;
            cpu_pkg::FWD_WB:  val = wb_val;
            default:          val = reg_val;
        endcase
        return val;
    endfunction

    // operand muxes
    assign op_a   = resolve(fwd_a_sel, ex.a_data, mem_fwd, wb_fwd);
    assign ry_val = resolve(fwd_b_sel, ex.b_data, mem_fwd, wb_fwd);
    assign op_b   = ex.ctrl.b_is_imm ? ex.imm : ry_val;

    always_comb begin
        case (ex.ctrl.alu_op)
            cpu_pkg::ALU_SUB:    alu_y = op_a - op_b;
            cpu_pkg::ALU_PASS_B: alu_y = op_b;
            default:             alu_y = op_a + op_b;
        endcase
    end

    always_comb begin
        result.reg_write  = ex.ctrl.reg_write;
        result.wb_sel     = ex.ctrl.wb_sel;
        result.mem_read   = ex.ctrl.mem_read;
        result.mem_write  = ex.ctrl.mem_write;
        result.dest       = ex.ctrl.dest;
        result.alu_result = alu_y;
        result.store_data = ry_val;
    end

    // branch resolution, target relative to the next pc
    assign branch_target = ex.pc_next + ex.imm;

    always_comb begin
        case (ex.ctrl.branch)
            cpu_pkg::BR_ALWAYS: branch_taken = 1'b1;
            cpu_pkg::BR_ZERO:   branch_taken = (op_a == '0);
            default:            branch_taken = 1'b0;
        endcase
    end

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top #(
    parameter cpu_pkg::addr_t RESET_PC = '0
) (
    input  logic           clk_50MHz,
    input  logic           rst,
    output cpu_pkg::addr_t imem_addr,
    input  cpu_pkg::inst_t imem_data,
    output cpu_pkg::addr_t dmem_addr,
    output cpu_pkg::data_t dmem_wdata,
    output logic           dmem_we,
    input  cpu_pkg::data_t dmem_rdata
);

    cpu_pkg::inst_t     if_inst;
    cpu_pkg::addr_t     if_pc_next;
    logic               load_stall;
    logic               branch_taken;
    cpu_pkg::addr_t     branch_target;

    cpu_pkg::ctrl_t     dec_ctrl;
    cpu_pkg::data_t     dec_imm;
    cpu_pkg::reg_addr_t id_rx;
    cpu_pkg::reg_addr_t id_ry;
    cpu_pkg::data_t     rf_data_a;
    cpu_pkg::data_t     rf_data_b;
    logic               id_b_is_imm;

    cpu_pkg::id_ex_t    id_ex_d;
    cpu_pkg::id_ex_t    id_ex;
    cpu_pkg::fwd_sel_t  fwd_a_sel;
    cpu_pkg::fwd_sel_t  fwd_b_sel;
    cpu_pkg::ex_mem_t   ex_result;
    cpu_pkg::ex_mem_t   ex_mem;
    cpu_pkg::mem_wb_t   mem_wb_d;
    cpu_pkg::mem_wb_t   mem_wb;

    // ************************************************************************
    // fetch and decode
    // ************************************************************************

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk_50MHz     (clk_50MHz),
        .rst           (rst),
        .load_stall    (load_stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_data     (imem_data),
        .imem_addr     (imem_addr),
        .if_inst       (if_inst),
        .if_pc_next    (if_pc_next)
    );

    decoder u_decoder (
        .inst (if_inst),
        .ctrl (dec_ctrl),
        .imm  (dec_imm)
    );

    assign id_rx = if_inst[cpu_pkg::RX_HI:cpu_pkg::RX_LO];
    assign id_ry = if_inst[cpu_pkg::RY_HI:cpu_pkg::RY_LO];

    reg_file u_reg_file (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .rd_addr_a (id_rx),
        .rd_addr_b (id_ry),
        .wb        (mem_wb),
        .rd_data_a (rf_data_a),
        .rd_data_b (rf_data_b)
    );

    // a store reads ry as its data even though operand b is the immediate
    assign id_b_is_imm = dec_ctrl.b_is_imm && !dec_ctrl.mem_write;

    hazard_unit u_hazard (
        .id_rx       (id_rx),
        .id_ry       (id_ry),
        .id_b_is_imm (id_b_is_imm),
        .ex          (id_ex),
        .mem         (ex_mem),
        .wb          (mem_wb),
        .load_stall  (load_stall),
        .fwd_a_sel   (fwd_a_sel),
        .fwd_b_sel   (fwd_b_sel)
    );

    always_comb begin
        id_ex_d.ctrl    = dec_ctrl;
        id_ex_d.pc_next = if_pc_next;
        id_ex_d.a_data  = rf_data_a;
        id_ex_d.b_data  = rf_data_b;
        id_ex_d.imm     = dec_imm;
        id_ex_d.rx      = id_rx;
        id_ex_d.ry      = id_ry;
    end

    // ID/EX, bubble on load stall or taken branch
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_ex <= '0;
        end else if (load_stall || branch_taken) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

    // ************************************************************************
    // execute, memory, writeback
    // ************************************************************************

    execute_unit u_execute (
        .ex            (id_ex),
        .fwd_a_sel     (fwd_a_sel),
        .fwd_b_sel     (fwd_b_sel),
        .mem_fwd       (ex_mem.alu_result),
        .wb_fwd        (mem_wb.wb_data),
        .result        (ex_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_result;
        end
    end

    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.mem_write;

    always_comb begin
        mem_wb_d.reg_write = ex_mem.reg_write;
        mem_wb_d.dest      = ex_mem.dest;
        mem_wb_d.wb_data   = (ex_mem.wb_sel == cpu_pkg::WB_MEM) ? dmem_rdata : ex_mem.alu_result;
    end

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= mem_wb_d;
        end
    end

endmodule

/* test/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 2,
    parameter int DRIVE_DELAY  = 2
) (
    input  logic rst_req,
    output logic clk_50MHz,
    output logic rst
);

    initial begin
        clk_50MHz = 1'b0;
        forever begin
            #HALF_PERIOD clk_50MHz = ~clk_50MHz;
        end
    end

    // active low, at power-up and again on each rising rst_req
    initial begin
        rst = 1'b0;
        forever begin
            repeat (RESET_CYCLES) @(posedge clk_50MHz);
            #DRIVE_DELAY rst = 1'b1;
            @(posedge rst_req);
            rst = 1'b0;
        end
    end

endmodule

/* test/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;

    localparam int NUM_CASES   = 5;
    localparam int MAX_PROG    = 16;
    localparam int MAX_STORES  = 8;
    localparam int RUN_CYCLES  = 32;
    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam cpu_pkg::addr_t RESET_PC = 16'h0008;

    // expected data may be a random data word plus an offset
    typedef struct packed {
        cpu_pkg::addr_t addr;
        cpu_pkg::data_t data;
        logic           from_mem;
        logic [2:0]     mem_idx;
    } store_t;

    logic           clk_50MHz;
    logic           rst;
    logic           rst_req;
    cpu_pkg::addr_t imem_addr;
    cpu_pkg::inst_t imem_data;
    cpu_pkg::addr_t dmem_addr;
    cpu_pkg::data_t dmem_wdata;
    logic           dmem_we;
    cpu_pkg::data_t dmem_rdata;

    cpu_pkg::inst_t imem [256];
    cpu_pkg::data_t dmem [256];
    cpu_pkg::data_t rand_words [8];

    cpu_pkg::inst_t prog [NUM_CASES][MAX_PROG];
    int             prog_len [NUM_CASES];
    store_t         want_tab [NUM_CASES][MAX_STORES];
    int             want_len [NUM_CASES];
    int             cur;

    store_t         seen [$];
    int             seen_cycle [$];
    store_t         observed;
    logic           recording;
    int             cycle;
    int             error_count;
    int             check_count;
    integer         seed;

    clock_gen #(
        .HALF_PERIOD  (CLK_PERIOD / 2),
        .RESET_CYCLES (2),
        .DRIVE_DELAY  (DRIVE_DELAY)
    ) u_clock (
        .rst_req   (rst_req),
        .clk_50MHz (clk_50MHz),
        .rst       (rst)
    );

    cpu_top #(.RESET_PC(RESET_PC)) UUT (
        .clk_50MHz  (clk_50MHz),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // ******************************************************************
    // memory models
    // ******************************************************************

    assign imem_data  = imem[imem_addr[7:0]];
    assign dmem_rdata = dmem[dmem_addr[7:0]];

    always @(posedge clk_50MHz) begin
        if (dmem_we === 1'b1) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    // stores sampled mid-cycle
    always @(negedge clk_50MHz) begin
        if (recording) begin
            if (dmem_we === 1'b1) begin
                observed.addr     = dmem_addr;
                observed.data     = dmem_wdata;
                observed.from_mem = 1'b0;
                observed.mem_idx  = 3'd0;
                seen.push_back(observed);
                seen_cycle.push_back(cycle);
            end
            cycle++;
        end
    end

    // ******************************************************************
    // instruction encoding and table building
    // ******************************************************************

    function automatic cpu_pkg::inst_t imm8_form(
        input cpu_pkg::opcode_t op,
        input int               rx,
        input int               imm
    );
        cpu_pkg::inst_t w;
        w = '0;
        w[cpu_pkg::OP_HI:cpu_pkg::OP_LO]     = op;
        w[cpu_pkg::RX_HI:cpu_pkg::RX_LO]     = rx[2:0];
        w[cpu_pkg::IMM8_HI:cpu_pkg::IMM_LO] = imm[7:0];
        return w;
    endfunction

    function automatic cpu_pkg::inst_t rrr_form(
        input int         rx,
        input int         ry,
        input int         rz,
        input logic [1:0] funct
    );
        cpu_pkg::inst_t w;
        w = '0;
        w[cpu_pkg::OP_HI:cpu_pkg::OP_LO]       = cpu_pkg::OP_RRR;
        w[cpu_pkg::RX_HI:cpu_pkg::RX_LO]       = rx[2:0];
        w[cpu_pkg::RY_HI:cpu_pkg::RY_LO]       = ry[2:0];
        w[cpu_pkg::RZ_HI:cpu_pkg::RZ_LO]       = rz[2:0];
        w[cpu_pkg::FUNCT_HI:cpu_pkg::FUNCT_LO] = funct;
        return w;
    endfunction

    function automatic cpu_pkg::inst_t mem_form(
        input cpu_pkg::opcode_t op,
        input int               rx,
        input int               ry,
        input int               imm
    );
        cpu_pkg::inst_t w;
        w = '0;
        w[cpu_pkg::OP_HI:cpu_pkg::OP_LO]     = op;
        w[cpu_pkg::RX_HI:cpu_pkg::RX_LO]     = rx[2:0];
        w[cpu_pkg::RY_HI:cpu_pkg::RY_LO]     = ry[2:0];
        w[cpu_pkg::IMM5_HI:cpu_pkg::IMM_LO] = imm[4:0];
        return w;
    endfunction

    function automatic cpu_pkg::inst_t b_form(input int imm);
        cpu_pkg::inst_t w;
        w = '0;
        w[cpu_pkg::OP_HI:cpu_pkg::OP_LO]      = cpu_pkg::OP_B;
        w[cpu_pkg::IMM11_HI:cpu_pkg::IMM_LO] = imm[10:0];
        return w;
    endfunction

    task automatic start_case(input int c);
        cur         = c;
        prog_len[c] = 0;
        want_len[c] = 0;
    endtask

    task automatic put(input cpu_pkg::inst_t w);
        prog[cur][prog_len[cur]] = w;
        prog_len[cur]++;
    endtask

    // mem_idx below zero means a plain expected value
    task automatic want(input cpu_pkg::addr_t addr, input cpu_pkg::data_t data, input int mem_idx);
        store_t e;
        e.addr     = addr;
        e.data     = data;
        e.from_mem = (mem_idx >= 0);
        e.mem_idx  = (mem_idx >= 0) ? mem_idx[2:0] : 3'd0;
        want_tab[cur][want_len[cur]] = e;
        want_len[cur]++;
    endtask

    task automatic build_table;
        // immediates and wrapping arithmetic
        start_case(0);
        put(imm8_form(cpu_pkg::OP_LI, 1, 'h80));
        put(imm8_form(cpu_pkg::OP_LI, 2, 'hf0));
        put(imm8_form(cpu_pkg::OP_ADDIU, 1, -5));
        put(imm8_form(cpu_pkg::OP_ADDIU, 2, 127));
        put(rrr_form(1, 2, 3, cpu_pkg::FUNCT_ADDU));
        put(rrr_form(1, 2, 4, cpu_pkg::FUNCT_SUBU));
        put(imm8_form(cpu_pkg::OP_LI, 0, 'h10));
        put(mem_form(cpu_pkg::OP_SW, 0, 1, 0));
        put(mem_form(cpu_pkg::OP_SW, 0, 2, 1));
        put(mem_form(cpu_pkg::OP_SW, 0, 3, 2));
        put(mem_form(cpu_pkg::OP_SW, 0, 4, 3));
        put(b_form(-1));
        want(16'h0010, 16'h007b, -1);
        want(16'h0011, 16'h016f, -1);
        want(16'h0012, 16'h01ea, -1);
        want(16'h0013, 16'hff0c, -1);

        // dependent chains one and two apart
        start_case(1);
        put(imm8_form(cpu_pkg::OP_LI, 1, 3));
        put(rrr_form(1, 1, 2, cpu_pkg::FUNCT_ADDU));
        put(rrr_form(2, 1, 3, cpu_pkg::FUNCT_ADDU));
        put(rrr_form(3, 2, 4, cpu_pkg::FUNCT_SUBU));
        put(imm8_form(cpu_pkg::OP_ADDIU, 4, -2));
        put(rrr_form(4, 3, 4, cpu_pkg::FUNCT_ADDU));
        put(imm8_form(cpu_pkg::OP_LI, 5, 'h20));
        put(mem_form(cpu_pkg::OP_SW, 5, 4, 0));
        put(mem_form(cpu_pkg::OP_SW, 5, 3, 1));
        put(imm8_form(cpu_pkg::OP_ADDIU, 5, 2));
        put(mem_form(cpu_pkg::OP_SW, 5, 2, 0));
        put(b_form(-1));
        want(16'h0020, 16'h000a, -1);
        want(16'h0021, 16'h0009, -1);
        want(16'h0022, 16'h0006, -1);

        // loads followed at once by a user
        start_case(2);
        put(imm8_form(cpu_pkg::OP_LI, 1, 2));
        put(mem_form(cpu_pkg::OP_LW, 1, 0, 3));
        put(imm8_form(cpu_pkg::OP_ADDIU, 1, 'h11));
        put(imm8_form(cpu_pkg::OP_LI, 2, 'h30));
        put(mem_form(cpu_pkg::OP_SW, 2, 1, 0));
        put(imm8_form(cpu_pkg::OP_LI, 3, 7));
        put(mem_form(cpu_pkg::OP_LW, 3, 0, -1));
        put(mem_form(cpu_pkg::OP_SW, 2, 3, 1));
        put(mem_form(cpu_pkg::OP_LW, 4, 0, 0));
        put(imm8_form(cpu_pkg::OP_ADDIU, 4, -16));
        put(mem_form(cpu_pkg::OP_SW, 2, 4, 2));
        put(b_form(-1));
        want(16'h0030, 16'h0011, 5);
        want(16'h0031, 16'h0000, 6);
        want(16'h0032, 16'hfff0, 0);

        // taken, untaken and unconditional branches
        start_case(3);
        put(imm8_form(cpu_pkg::OP_LI, 1, 'h40));
        put(imm8_form(cpu_pkg::OP_BEQZ, 0, 2));
        put(mem_form(cpu_pkg::OP_SW, 1, 1, 0));
        put(mem_form(cpu_pkg::OP_SW, 1, 1, 1));
        put(imm8_form(cpu_pkg::OP_LI, 2, 5));
        put(imm8_form(cpu_pkg::OP_BEQZ, 2, 2));
        put(mem_form(cpu_pkg::OP_SW, 1, 2, 2));
        put(b_form(2));
        put(mem_form(cpu_pkg::OP_SW, 1, 1, 3));
        put(mem_form(cpu_pkg::OP_SW, 1, 1, 4));
        put(mem_form(cpu_pkg::OP_SW, 1, 2, 5));
        put(imm8_form(cpu_pkg::OP_ADDIU, 2, -5));
        put(imm8_form(cpu_pkg::OP_BEQZ, 2, 1));
        put(mem_form(cpu_pkg::OP_SW, 1, 1, 6));
        put(mem_form(cpu_pkg::OP_SW, 1, 1, 7));
        put(b_form(-1));
        want(16'h0042, 16'h0005, -1);
        want(16'h0045, 16'h0005, -1);
        want(16'h0047, 16'h0040, -1);

        // store order, negative offsets, dead stores past the final branch
        start_case(4);
        put(imm8_form(cpu_pkg::OP_LI, 1, 'h57));
        put(imm8_form(cpu_pkg::OP_LI, 2, 'h12));
        put(mem_form(cpu_pkg::OP_SW, 1, 2, -1));
        put(mem_form(cpu_pkg::OP_SW, 1, 1, -2));
        put(rrr_form(2, 1, 3, cpu_pkg::FUNCT_SUBU));
        put(mem_form(cpu_pkg::OP_SW, 1, 3, -16));
        put(mem_form(cpu_pkg::OP_SW, 1, 3, 15));
        put(rrr_form(3, 1, 3, cpu_pkg::FUNCT_ADDU));
        put(mem_form(cpu_pkg::OP_SW, 1, 3, 0));
        put(b_form(-1));
        put(mem_form(cpu_pkg::OP_SW, 1, 1, 1));
        put(mem_form(cpu_pkg::OP_SW, 1, 2, 2));
        want(16'h0056, 16'h0012, -1);
        want(16'h0055, 16'h0057, -1);
        want(16'h0047, 16'hffbb, -1);
        want(16'h0066, 16'hffbb, -1);
        want(16'h0057, 16'h0012, -1);
    endtask

    // ******************************************************************
    // checks
    // ******************************************************************

    task automatic check_addr(input cpu_pkg::addr_t got, input cpu_pkg::addr_t exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input cpu_pkg::data_t got, input cpu_pkg::data_t exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_stores(input int c);
        store_t         got;
        store_t         exp;
        cpu_pkg::data_t exp_data;
        int             n;
        int             first_sw;
        check_count++;
        if (seen.size() != want_len[c]) begin
            error_count++;
            $display("[FAIL] %0t: case %0d made %0d stores, expected %0d",
                     $time, c, seen.size(), want_len[c]);
        end
        n = (seen.size() < want_len[c]) ? seen.size() : want_len[c];
        for (int i = 0; i < n; i++) begin
            got      = seen[i];
            exp      = want_tab[c][i];
            exp_data = exp.from_mem ? exp.data + rand_words[exp.mem_idx] : exp.data;
            check_addr(got.addr, exp.addr, $sformatf("case %0d store %0d address", c, i));
            check_data(got.data, exp_data, $sformatf("case %0d store %0d data", c, i));
        end
        first_sw = prog_len[c];
        for (int i = prog_len[c] - 1; i >= 0; i--) begin
            if (prog[c][i][cpu_pkg::OP_HI:cpu_pkg::OP_LO] == cpu_pkg::OP_SW) begin
                first_sw = i;
            end
        end
        // an SW fetched in cycle n is in memory in cycle n+3 at the earliest
        check_count++;
        if (seen_cycle.size() > 0 && seen_cycle[0] < first_sw + 3) begin
            error_count++;
            $display("case %0d: a store showed up in cycle %0d, before any SW could reach memory",
                     c, seen_cycle[0]);
        end
    endtask

    // ******************************************************************
    // run loop
    // ******************************************************************

    task automatic clear_memories;
        for (int i = 0; i < 256; i++) begin
            imem[i] = cpu_pkg::NOP_INST;
            dmem[i] = {8'hd0, 8'(i)};
        end
    endtask

    task automatic load_case(input int c);
        integer r;
        clear_memories();
        for (int i = 0; i < prog_len[c]; i++) begin
            imem[RESET_PC[7:0] + i] = prog[c][i];
        end
        for (int i = 0; i < 8; i++) begin
            r             = $random(seed);
            rand_words[i] = r[15:0];
            dmem[i]       = r[15:0];
        end
    endtask

    task automatic run_case(input int c);
        @(posedge clk_50MHz);
        #DRIVE_DELAY;
        rst_req = 1'b1;
        wait (rst === 1'b0);
        load_case(c);
        rst_req = 1'b0;
        wait (rst === 1'b1);
        check_addr(imem_addr, RESET_PC, $sformatf("case %0d fetch address after reset", c));
        seen.delete();
        seen_cycle.delete();
        cycle     = 0;
        recording = 1'b1;
        repeat (RUN_CYCLES) @(posedge clk_50MHz);
        recording = 1'b0;
    endtask

    initial begin
        seed        = 32'h741f;
        rst_req     = 1'b0;
        recording   = 1'b0;
        cycle       = 0;
        error_count = 0;
        check_count = 0;
        clear_memories();
        build_table();
        // power-up reset, before the core has run anything
        @(negedge clk_50MHz);
        check_count++;
        if (dmem_we !== 1'b0) begin
            error_count++;
            $display("[FAIL] %0t: data memory write enable is %b during reset, expected 0",
                     $time, dmem_we);
        end
        wait (rst === 1'b1);
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
            compare_stores(c);
        end
        $display("%0d errors in %0d checks over %0d cases", error_count, check_count, NUM_CASES);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_CASES * 40 * CLK_PERIOD + 500);
        $display("watchdog expired before all cases had run");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* files.f */
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/execute_unit.sv
hw/cpu_top.sv
test/clock_gen.sv
test/cpu_tb.sv
